// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_rr_record -f vlog.f
	@out="$$(./obj_dir/Vtb_rr_record)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: rr_cfg_pkg.sv
package rr_cfg_pkg;

   // number of logged channels
   localparam int chan_cnt = 4;

   // one data byte per channel
   localparam int data_w = 8;

   // all channel bytes side by side, dense from byte 0
   localparam int packed_w = chan_cnt * data_w;

   // record length in bytes, header plus packed bytes (1 to 5)
   localparam int len_w = 3;

   // record body as seen by the serializer
   // msb to lsb: packed data, loge vector, logb vector
   localparam int rec_data_w = packed_w + 2 * chan_cnt;

   // one fifo entry is the record body with its length in the low bits
   localparam int rec_w = rec_data_w + len_w;

   // fifo addressing, 16 entries
   localparam int fifo_ptr_w = 4;
   localparam int fifo_depth = 1 << fifo_ptr_w;

   // almost-full when this many entries or fewer are free
   // packer stage + fifo almful reg + packer almful reg + one spare
   localparam int almful_thresh = 4;

endpackage

// File: rr_channel_packer.sv
`timescale 1ns/1ns

module rr_channel_packer (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]     logb_valid,
   input  logic [rr_cfg_pkg::packed_w-1:0]     logb_data,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]     loge_valid,
   input  logic                                fifo_almful,
   output logic                                plogb_valid,
   output logic [rr_cfg_pkg::chan_cnt-1:0]     plogb_logb,
   output logic [rr_cfg_pkg::chan_cnt-1:0]     plogb_loge,
   output logic [rr_cfg_pkg::packed_w-1:0]     plogb_data,
   output logic [rr_cfg_pkg::len_w-1:0]        plogb_len,
   output logic                                logb_almful
);

   // combinational pack result, registered below
   logic [rr_cfg_pkg::packed_w-1:0] pack_data;
   logic [rr_cfg_pkg::len_w-1:0]    pack_cnt;

   // priority pack loop
   // walk channels lowest first, every valid byte goes to the next free slot
   // slots above the last valid byte stay zero
   always_comb begin
      pack_data = '0;
      pack_cnt  = '0;
      for (int i = 0; i < rr_cfg_pkg::chan_cnt; i++) begin
         if (logb_valid[i]) begin
            pack_data[pack_cnt * rr_cfg_pkg::data_w +: rr_cfg_pkg::data_w] =
               logb_data[i * rr_cfg_pkg::data_w +: rr_cfg_pkg::data_w];
            pack_cnt = pack_cnt + rr_cfg_pkg::len_w'(1);
         end
      end
   end

   // event vectors and the push strobe
   // loge is carried every cycle, with or without a logb
   always_ff @(posedge clk) begin
      if (!rstn) begin
         plogb_valid <= 1'b0;
         plogb_logb  <= '0;
         plogb_loge  <= '0;
      end else begin
         // any begin means one record to push
         plogb_valid <= |logb_valid;
         plogb_logb  <= logb_valid;
         plogb_loge  <= loge_valid;
      end
   end

   // packed bytes and their count
   // only looked at while plogb_valid is high
   always_ff @(posedge clk) begin
      plogb_data <= pack_data;
      plogb_len  <= pack_cnt;
   end

   // almost-full back to the channels, one stage
   // the fifo threshold leaves room for this delay
   always_ff @(posedge clk) begin
      if (!rstn) begin
         logb_almful <= 1'b0;
      end else begin
         logb_almful <= fifo_almful;
      end
   end

endmodule

// File: rr_logb_fifo.sv
`timescale 1ns/1ns

module rr_logb_fifo (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         push,
   input  logic [rr_cfg_pkg::rec_w-1:0] push_data,
   input  logic                         pop,
   output logic [rr_cfg_pkg::rec_w-1:0] pop_data,
   output logic                         empty,
   output logic                         almful
);

   // record storage
   logic [rr_cfg_pkg::rec_w-1:0] mem [rr_cfg_pkg::fifo_depth];

   // pointers carry one extra wrap bit
   logic [rr_cfg_pkg::fifo_ptr_w:0] wr_ptr;
   logic [rr_cfg_pkg::fifo_ptr_w:0] rd_ptr;
   logic [rr_cfg_pkg::fifo_ptr_w:0] count;
   logic [rr_cfg_pkg::fifo_ptr_w:0] count_next;
   logic [rr_cfg_pkg::fifo_ptr_w:0] free_next;
   logic                            full;
   logic                            do_push;
   logic                            do_pop;

   // occupancy from the pointer difference
   assign count = wr_ptr - rd_ptr;
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (count == (rr_cfg_pkg::fifo_ptr_w + 1)'(rr_cfg_pkg::fifo_depth));

   // a push into a full fifo is dropped
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // first-word fall-through keeps the head on pop_data
   assign pop_data = mem[rd_ptr[rr_cfg_pkg::fifo_ptr_w-1:0]];

   // occupancy after this edge
   assign count_next = count
                     + (rr_cfg_pkg::fifo_ptr_w + 1)'(do_push)
                     - (rr_cfg_pkg::fifo_ptr_w + 1)'(do_pop);
   assign free_next  = (rr_cfg_pkg::fifo_ptr_w + 1)'(rr_cfg_pkg::fifo_depth) - count_next;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[rr_cfg_pkg::fifo_ptr_w-1:0]] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         almful <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // registered flag that matches the free count once this edge is done
         almful <= (free_next <= (rr_cfg_pkg::fifo_ptr_w + 1)'(rr_cfg_pkg::almful_thresh));
      end
   end

endmodule

// File: rr_packed2writeback_bus.sv
`timescale 1ns/1ns

module rr_packed2writeback_bus (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              plogb_valid,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]   plogb_logb,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]   plogb_loge,
   input  logic [rr_cfg_pkg::packed_w-1:0]   plogb_data,
   input  logic [rr_cfg_pkg::len_w-1:0]      plogb_len,
   input  logic                              rec_pop,
   output logic                              fifo_almful,
   output logic                              rec_valid,
   output logic [rr_cfg_pkg::rec_data_w-1:0] rec_data,
   output logic [rr_cfg_pkg::len_w-1:0]      rec_len
);

   // loge seen since the last pushed record
   // each bit means exactly one transaction ended on that channel
   logic [rr_cfg_pkg::chan_cnt-1:0] loge_valid_out;

   // fifo side
   logic                         fifo_push;
   logic [rr_cfg_pkg::rec_w-1:0] fifo_push_data;
   logic [rr_cfg_pkg::rec_w-1:0] fifo_pop_data;
   logic                         fifo_empty;
   logic [rr_cfg_pkg::len_w-1:0] rec_len_in;

   // every logb cycle becomes one record
   assign fifo_push = plogb_valid;

   // header byte plus the packed bytes
   assign rec_len_in = plogb_len + rr_cfg_pkg::len_w'(1);

   // msb to lsb: packed data, loge so far, logb, length
   // the loge of this same cycle is not in here, it goes to the next record
   assign fifo_push_data = {plogb_data, loge_valid_out, plogb_logb, rec_len_in};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         loge_valid_out <= '0;
      end else if (fifo_push) begin
         // old value is in the record now, restart with this cycle's loge
         loge_valid_out <= plogb_loge;
      end else begin
         // standalone loge, hold it for the next record
         loge_valid_out <= loge_valid_out | plogb_loge;
      end
   end

   rr_logb_fifo rr_logb_fifo_i (
      .clk       (clk),
      .rstn      (rstn),
      .push      (fifo_push),
      .push_data (fifo_push_data),
      .pop       (rec_pop),
      .pop_data  (fifo_pop_data),
      .empty     (fifo_empty),
      .almful    (fifo_almful)
   );

   // head record towards the serializer
   assign rec_valid = !fifo_empty;
   assign rec_data  = fifo_pop_data[rr_cfg_pkg::rec_w-1:rr_cfg_pkg::len_w];
   assign rec_len   = fifo_pop_data[rr_cfg_pkg::len_w-1:0];

endmodule

// File: rr_record_top.sv
`timescale 1ns/1ns

module rr_record_top (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]   logb_valid,
   input  logic [rr_cfg_pkg::packed_w-1:0]   logb_data,
   input  logic [rr_cfg_pkg::chan_cnt-1:0]   loge_valid,
   input  logic                              wb_ack,
   output logic                              logb_almful,
   output logic                              wb_req,
   output logic [rr_cfg_pkg::data_w-1:0]     wb_data
);

   // packer to buffer
   logic                              plogb_valid;
   logic [rr_cfg_pkg::chan_cnt-1:0]   plogb_logb;
   logic [rr_cfg_pkg::chan_cnt-1:0]   plogb_loge;
   logic [rr_cfg_pkg::packed_w-1:0]   plogb_data;
   logic [rr_cfg_pkg::len_w-1:0]      plogb_len;
   logic                              fifo_almful;

   // buffer to serializer
   logic                              rec_valid;
   logic [rr_cfg_pkg::rec_data_w-1:0] rec_data;
   logic [rr_cfg_pkg::len_w-1:0]      rec_len;
   logic                              rec_pop;

   rr_channel_packer rr_channel_packer_i (
      .clk         (clk),
      .rstn        (rstn),
      .logb_valid  (logb_valid),
      .logb_data   (logb_data),
      .loge_valid  (loge_valid),
      .fifo_almful (fifo_almful),
      .plogb_valid (plogb_valid),
      .plogb_logb  (plogb_logb),
      .plogb_loge  (plogb_loge),
      .plogb_data  (plogb_data),
      .plogb_len   (plogb_len),
      .logb_almful (logb_almful)
   );

   rr_packed2writeback_bus rr_packed2writeback_bus_i (
      .clk         (clk),
      .rstn        (rstn),
      .plogb_valid (plogb_valid),
      .plogb_logb  (plogb_logb),
      .plogb_loge  (plogb_loge),
      .plogb_data  (plogb_data),
      .plogb_len   (plogb_len),
      .rec_pop     (rec_pop),
      .fifo_almful (fifo_almful),
      .rec_valid   (rec_valid),
      .rec_data    (rec_data),
      .rec_len     (rec_len)
   );

   rr_writeback_serializer rr_writeback_serializer_i (
      .clk       (clk),
      .rstn      (rstn),
      .rec_valid (rec_valid),
      .rec_data  (rec_data),
      .rec_len   (rec_len),
      .wb_ack    (wb_ack),
      .rec_pop   (rec_pop),
      .wb_req    (wb_req),
      .wb_data   (wb_data)
   );

endmodule

// File: rr_state_pkg.sv
package rr_state_pkg;

   // writeback serializer states
   // st_idle     no record held, waiting for the fifo head
   // st_drive    byte on wb_data, wb_req high, waiting for ack
   // st_release  ack seen, wb_req dropped, waiting for ack to fall
   typedef enum logic [1:0] {
      st_idle    = 2'd0,
      st_drive   = 2'd1,
      st_release = 2'd2
   } ser_state_t;

endpackage

// File: rr_writeback_serializer.sv
`timescale 1ns/1ns

module rr_writeback_serializer (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              rec_valid,
   input  logic [rr_cfg_pkg::rec_data_w-1:0] rec_data,
   input  logic [rr_cfg_pkg::len_w-1:0]      rec_len,
   input  logic                              wb_ack,
   output logic                              rec_pop,
   output logic                              wb_req,
   output logic [rr_cfg_pkg::data_w-1:0]     wb_data
);

   rr_state_pkg::ser_state_t state;

   // local copy of the record being sent
   // byte k of the record is rec_reg[k*8 +: 8], header first
   logic [rr_cfg_pkg::rec_data_w-1:0] rec_reg;
   logic [rr_cfg_pkg::len_w-1:0]      len_reg;
   logic [rr_cfg_pkg::len_w-1:0]      byte_idx;
   logic [rr_cfg_pkg::len_w-1:0]      next_idx;
   logic                              last_byte;

   assign next_idx  = byte_idx + rr_cfg_pkg::len_w'(1);
   assign last_byte = (next_idx == len_reg);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= rr_state_pkg::st_idle;
         rec_pop  <= 1'b0;
         wb_req   <= 1'b0;
         byte_idx <= '0;
      end else begin
         // strobe lasts one cycle
         rec_pop <= 1'b0;
         case (state)
            rr_state_pkg::st_idle: begin
               if (rec_pop) begin
                  // head still on rec_data while the pop is in flight
                  // header byte is the low byte of the record
                  rec_reg  <= rec_data;
                  len_reg  <= rec_len;
                  byte_idx <= '0;
                  wb_data  <= rec_data[rr_cfg_pkg::data_w-1:0];
                  wb_req   <= 1'b1;
                  state    <= rr_state_pkg::st_drive;
               end else if (rec_valid) begin
                  rec_pop <= 1'b1;
               end
            end
            rr_state_pkg::st_drive: begin
               // wb_data held until the receiver has it
               if (wb_ack) begin
                  wb_req <= 1'b0;
                  state  <= rr_state_pkg::st_release;
               end
            end
            rr_state_pkg::st_release: begin
               // four-phase, wait for ack low before the next byte
               if (!wb_ack) begin
                  if (last_byte) begin
                     state <= rr_state_pkg::st_idle;
                  end else begin
                     byte_idx <= next_idx;
                     wb_data  <= rec_reg[next_idx * rr_cfg_pkg::data_w +: rr_cfg_pkg::data_w];
                     wb_req   <= 1'b1;
                     state    <= rr_state_pkg::st_drive;
                  end
               end
            end
            default: begin
               wb_req <= 1'b0;
               state  <= rr_state_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
   output logic clk,
   output logic rstn
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset low over four rising edges, released just after the fourth
   initial begin
      rstn = 1'b0;
      repeat (4) @(posedge clk);
      #1 rstn = 1'b1;
   end

endmodule

// File: tb_rr_record.sv
`timescale 1ns/1ns

module tb_rr_record;

   // the whole run takes a few thousand cycles
   // the slow-ack test is the longest
   localparam int max_cycles = 20000;
   // longest wait for the bytes of one test
   localparam int drain_limit = 4000;

   logic                                clk;
   logic                                rstn;
   logic [rr_cfg_pkg::chan_cnt-1:0]     logb_valid;
   logic [rr_cfg_pkg::packed_w-1:0]     logb_data;
   logic [rr_cfg_pkg::chan_cnt-1:0]     loge_valid;
   logic                                wb_ack;
   logic                                logb_almful;
   logic                                wb_req;
   logic [rr_cfg_pkg::data_w-1:0]       wb_data;

   // predicted bytes and received bytes
   logic [7:0] exp_q[$];
   logic [7:0] rcv_q[$];
   // loge waiting for the header of the next record
   logic [3:0] loge_acc;
   int         err_cnt;
   int         cycle_cnt;
   // receiver ack delay range in cycles
   int         ack_min = 0;
   int         ack_max = 0;

   tb_clkgen tb_clkgen_i (
      .clk  (clk),
      .rstn (rstn)
   );

   rr_record_top rr_record_top_i (
      .clk         (clk),
      .rstn        (rstn),
      .logb_valid  (logb_valid),
      .logb_data   (logb_data),
      .loge_valid  (loge_valid),
      .wb_ack      (wb_ack),
      .logb_almful (logb_almful),
      .wb_req      (wb_req),
      .wb_data     (wb_data)
   );

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
         err_cnt++;
      end
   endtask

   // advance to 1 ns past the next rising edge
   // inputs change here and outputs have settled
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   // one cycle of events plus the bytes they must produce
   task automatic apply(input logic [3:0] lb, input logic [31:0] data, input logic [3:0] le);
      int i;
      logb_valid = lb;
      logb_data  = data;
      loge_valid = le;
      if (lb != 4'd0) begin
         // header has logb in the low nibble and the held loge in the high nibble
         exp_q.push_back({loge_acc, lb});
         for (i = 0; i < 4; i++) begin
            if (lb[i]) begin
               exp_q.push_back(data[i*8 +: 8]);
            end
         end
         // a loge next to this logb belongs to the record after
         loge_acc = le;
      end else begin
         loge_acc = loge_acc | le;
      end
   endtask

   // wait for all predicted bytes and compare them in order
   task automatic drain_compare(input string name);
      int waited;
      int n;
      int i;
      waited = 0;
      while ((rcv_q.size() < exp_q.size() || wb_req) && waited < drain_limit) begin
         step();
         waited++;
      end
      if (waited >= drain_limit) begin
         $display("ERROR %s: only %0d of %0d bytes arrived before the wait ran out",
                  name, rcv_q.size(), exp_q.size());
         err_cnt++;
      end
      // a quiet spell catches bytes nobody predicted
      repeat (20) step();
      check_val({name, " byte count"}, 32'(exp_q.size()), 32'(rcv_q.size()));
      n = (rcv_q.size() < exp_q.size()) ? rcv_q.size() : exp_q.size();
      for (i = 0; i < n; i++) begin
         check_val($sformatf("%s byte %0d", name, i), 32'(exp_q[i]), 32'(rcv_q[i]));
      end
      exp_q.delete();
      rcv_q.delete();
   endtask

   // four-phase receiver
   initial begin
      int delay;
      wb_ack = 1'b0;
      forever begin
         step();
         if (wb_req && !wb_ack) begin
            delay = int'($urandom_range(ack_max, ack_min));
            if (delay > 0) begin
               repeat (delay) @(posedge clk);
               #1;
            end
            // data is stable while req is high
            rcv_q.push_back(wb_data);
            wb_ack = 1'b1;
            while (wb_req) begin
               step();
            end
            wb_ack = 1'b0;
         end
      end
   end

   task automatic reset_idle();
      check_val("reset wb_req", 32'd0, 32'(wb_req));
      check_val("reset logb_almful", 32'd0, 32'(logb_almful));
      // nothing may come out without events
      repeat (20) step();
      check_val("reset no bytes", 32'd0, 32'(rcv_q.size()));
   endtask

   task automatic single_logb();
      // header 0x04 then 0xa5
      step();
      apply(4'b0100, 32'h33a5_2211, 4'b0000);
      step();
      apply('0, '0, '0);
      drain_compare("single_logb");
   endtask

   task automatic multi_channel();
      // header 0x0b then a1 b2 d4
      // the channel 2 byte is not packed
      step();
      apply(4'b1011, 32'hd4c3_b2a1, 4'b0000);
      step();
      apply('0, '0, '0);
      drain_compare("multi_channel");
   endtask

   task automatic loge_accum();
      // standalone loge on ch1 and ch3 in separate cycles
      step();
      apply('0, '0, 4'b0010);
      step();
      apply('0, '0, 4'b1000);
      step();
      apply('0, '0, '0);
      // header 0xa1
      // the ch2 loge rides into the next record
      step();
      apply(4'b0001, 32'h0000_0077, 4'b0100);
      step();
      apply('0, '0, '0);
      // header 0x42
      step();
      apply(4'b0010, 32'h0000_8800, '0);
      step();
      apply('0, '0, '0);
      drain_compare("loge_accum");
   endtask

   task automatic backpressure();
      int c;
      int sent;
      int sent_at_full;
      logic rose;
      sent = 0;
      sent_at_full = 0;
      rose = 1'b0;
      ack_min = 8;
      ack_max = 8;
      for (c = 0; c < 100; c++) begin
         step();
         if (logb_almful) begin
            if (!rose) begin
               rose = 1'b1;
               sent_at_full = sent;
            end
            apply('0, '0, '0);
         end else begin
            apply(4'($urandom_range(15, 1)), $urandom(), '0);
            sent++;
         end
      end
      step();
      apply('0, '0, '0);
      check_val("backpressure almful rose", 32'd1, 32'(rose));
      check_val("backpressure under 16 outstanding", 32'd1, 32'(sent_at_full < 16));
      drain_compare("backpressure");
      ack_min = 0;
      ack_max = 0;
   endtask

   task automatic random_mix();
      int c;
      logic [3:0] lb;
      logic [3:0] le;
      ack_min = 0;
      ack_max = 3;
      for (c = 0; c < 200; c++) begin
         step();
         lb = '0;
         if (!logb_almful && $urandom_range(1, 0) == 1) begin
            lb = 4'($urandom_range(15, 1));
         end
         le = 4'($urandom_range(15, 0));
         if ($urandom_range(3, 0) != 0) begin
            le = '0;
         end
         // one standalone loge per channel until the next logb
         if (lb == 4'd0) begin
            le = le & ~loge_acc;
         end
         apply(lb, $urandom(), le);
      end
      step();
      apply('0, '0, '0);
      // one last record carries out any held loge
      step();
      while (logb_almful) begin
         step();
      end
      apply(4'hf, $urandom(), '0);
      step();
      apply('0, '0, '0);
      drain_compare("random_mix");
      ack_max = 0;
   endtask

   // run limit
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < max_cycles) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("TIMEOUT: the tests did not finish within %0d cycles", max_cycles);
      $display("closing: %0d errors before the timeout", err_cnt);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(44));
      err_cnt    = 0;
      loge_acc   = '0;
      logb_valid = '0;
      logb_data  = '0;
      loge_valid = '0;
      wait (rstn === 1'b1);
      step();
      reset_idle();
      single_logb();
      multi_channel();
      loge_accum();
      backpressure();
      random_mix();
      $display("closing: %0d errors", err_cnt);
      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
rr_cfg_pkg.sv
rr_state_pkg.sv
rr_logb_fifo.sv
rr_channel_packer.sv
rr_packed2writeback_bus.sv
rr_writeback_serializer.sv
rr_record_top.sv
tb_clkgen.sv
tb_rr_record.sv
